// ==== src/weight_cache_config.svh ====
/*
 * Weight cache configuration
 * Port count, address and data widths, tag store depth
 */
`ifndef WEIGHT_CACHE_CONFIG_SVH
`define WEIGHT_CACHE_CONFIG_SVH

// Processing-element ports
`define WC_NUM_PORTS 4

// Weight RAM address and weight width
`define WC_ADDR_W 13
`define WC_DATA_W 8

// Tag store depth
`define WC_NUM_SLOTS 16

`endif

// ==== src/weight_cache_pkg.sv ====
/*
 * Weight cache shared types
 * Addresses, weights, port and slot numbers, job state
 */
`include "weight_cache_config.svh"

package weight_cache_pkg;

    typedef logic [`WC_ADDR_W-1:0] addr_t;
    typedef logic [`WC_DATA_W-1:0] data_t;

    typedef logic [$clog2(`WC_NUM_PORTS)-1:0] port_idx_t;
    typedef logic [$clog2(`WC_NUM_SLOTS)-1:0] slot_idx_t;

    // Job controller states
    typedef enum logic [1:0] {
        JOB_IDLE   = 2'd0,
        JOB_CONFIG = 2'd1,
        JOB_WORK   = 2'd2
    } job_state_t;

endpackage

// ==== src/port_bus_if.sv ====
/*
 * Port to RAM arbiter bus
 * Miss request with address, one-cycle response with data
 */
`timescale 1ns/1ps

interface port_bus_if;

    // Miss held by the port until the response pulse
    logic                    miss_req;
    weight_cache_pkg::addr_t miss_addr;

    // RAM data routed back by the arbiter
    logic                    rsp_vld;
    weight_cache_pkg::data_t rsp_dat;

    modport port (
        output miss_req,
        output miss_addr,
        input  rsp_vld,
        input  rsp_dat
    );

    modport arb (
        input  miss_req,
        input  miss_addr,
        output rsp_vld,
        output rsp_dat
    );

endinterface

// ==== src/cache_ctrl.sv ====
/*
 * Weight cache job controller
 * Idle, config and work states, latches the cache/bypass mode
 */
`timescale 1ns/1ps

module cache_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic cfg_vld,
    input  logic cfg_cache_en,
    output logic cfg_rdy,
    output logic work,
    output logic cache_en
);

    weight_cache_pkg::job_state_t state_q;
    weight_cache_pkg::job_state_t state_d;
    logic                         mode_q;

    // ==================================================
    // Job FSM
    // ==================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            weight_cache_pkg::JOB_IDLE:   if (cfg_vld) state_d = weight_cache_pkg::JOB_CONFIG;
            weight_cache_pkg::JOB_CONFIG: state_d = weight_cache_pkg::JOB_WORK;
            weight_cache_pkg::JOB_WORK:   if (cfg_vld) state_d = weight_cache_pkg::JOB_IDLE;
            default:                      state_d = weight_cache_pkg::JOB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= weight_cache_pkg::JOB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Mode taken on the way out of config, dropped before idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q <= 1'b0;
        end else if (state_q == weight_cache_pkg::JOB_CONFIG) begin
            mode_q <= cfg_cache_en;
        end else if (state_d == weight_cache_pkg::JOB_IDLE) begin
            mode_q <= 1'b0;
        end
    end

    assign cfg_rdy  = (state_q == weight_cache_pkg::JOB_IDLE);
    assign work     = (state_q == weight_cache_pkg::JOB_WORK);
    assign cache_en = mode_q;

endmodule

// ==== src/weight_tag_store.sv ====
/*
 * Weight tag store
 * Preloaded tags filled in rotating order, data filled from RAM
 * responses, lowest-slot lookup for every port
 */
`timescale 1ns/1ps
`include "weight_cache_config.svh"

module weight_tag_store (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        work,
    input  logic                                        cache_en,
    input  logic                                        idx_vld,
    input  weight_cache_pkg::addr_t                     idx_addr,
    output logic                                        idx_rdy,
    input  logic                                        fill_vld,
    input  weight_cache_pkg::addr_t                     fill_addr,
    input  weight_cache_pkg::data_t                     fill_dat,
    input  weight_cache_pkg::addr_t [`WC_NUM_PORTS-1:0] lookup_addr,
    output logic [`WC_NUM_PORTS-1:0]                    hit,
    output weight_cache_pkg::data_t [`WC_NUM_PORTS-1:0] hit_dat
);

    weight_cache_pkg::addr_t     tag_q [`WC_NUM_SLOTS];
    weight_cache_pkg::data_t     dat_q [`WC_NUM_SLOTS];
    logic [`WC_NUM_SLOTS-1:0]    tag_vld_q;
    logic [`WC_NUM_SLOTS-1:0]    dat_vld_q;
    weight_cache_pkg::slot_idx_t wr_ptr_q;
    logic                        preload;
    logic [`WC_NUM_SLOTS-1:0]    fill_match;
    weight_cache_pkg::slot_idx_t fill_slot;
    logic                        fill_wr;

    // Lowest set bit wins
    function automatic weight_cache_pkg::slot_idx_t lowest_slot(
        input logic [`WC_NUM_SLOTS-1:0] vec
    );
        weight_cache_pkg::slot_idx_t idx;
        idx = '0;
        for (int s = `WC_NUM_SLOTS - 1; s >= 0; s--) begin
            if (vec[s]) idx = weight_cache_pkg::slot_idx_t'(s);
        end
        return idx;
    endfunction

    assign idx_rdy = work & cache_en;
    assign preload = idx_vld & idx_rdy;

    // ==================================================
    // Fill from RAM responses
    // ==================================================
    for (genvar s = 0; s < `WC_NUM_SLOTS; s++) begin : g_fill
        assign fill_match[s] = tag_vld_q[s] & ~dat_vld_q[s] & (tag_q[s] == fill_addr);
    end

    assign fill_slot = lowest_slot(fill_match);
    assign fill_wr   = work & cache_en & fill_vld & (|fill_match);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_vld_q <= '0;
            dat_vld_q <= '0;
            wr_ptr_q  <= '0;
        end else if (!work) begin
            tag_vld_q <= '0;
            dat_vld_q <= '0;
            wr_ptr_q  <= '0;
        end else begin
            if (fill_wr) dat_vld_q[fill_slot] <= 1'b1;
            // A new index overrides a fill to the same slot
            if (preload) begin
                tag_vld_q[wr_ptr_q] <= 1'b1;
                dat_vld_q[wr_ptr_q] <= 1'b0;
                wr_ptr_q            <= wr_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_wr) dat_q[fill_slot] <= fill_dat;
        if (preload) tag_q[wr_ptr_q] <= idx_addr;
    end

    // ==================================================
    // Per-port lookup
    // ==================================================
    for (genvar p = 0; p < `WC_NUM_PORTS; p++) begin : g_lookup
        logic [`WC_NUM_SLOTS-1:0]    match;
        weight_cache_pkg::slot_idx_t slot;

        for (genvar s = 0; s < `WC_NUM_SLOTS; s++) begin : g_cmp
            assign match[s] = tag_vld_q[s] & (tag_q[s] == lookup_addr[p]);
        end

        assign slot       = lowest_slot(match);
        assign hit[p]     = cache_en & (|match) & dat_vld_q[slot];
        assign hit_dat[p] = dat_q[slot];
    end

endmodule

// ==== src/weight_port.sv ====
/*
 * Weight cache port
 * Answers hits from the tag store, sends misses to the arbiter,
 * holds one response until the PE takes it
 */
`timescale 1ns/1ps

module weight_port (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    work,
    input  logic                    req_vld,
    input  weight_cache_pkg::addr_t req_addr,
    output logic                    req_rdy,
    input  logic                    rsp_rdy,
    output logic                    rsp_vld,
    output weight_cache_pkg::data_t rsp_dat,
    output weight_cache_pkg::addr_t lookup_addr,
    input  logic                    hit,
    input  weight_cache_pkg::data_t hit_dat,
    port_bus_if.port                bus
);

    logic rsp_free;
    logic hit_take;
    logic miss_now;
    logic miss_busy_q;
    logic rsp_load;

    assign lookup_addr = req_addr;

    // Register empty, or emptied this cycle
    assign rsp_free = ~rsp_vld | rsp_rdy;

    // ==================================================
    // Hit or miss decision
    // ==================================================
    assign hit_take = work & req_vld & hit & rsp_free & ~miss_busy_q;
    assign miss_now = work & req_vld & ~hit & ~rsp_vld;

    // Once raised, a miss stays up until its data returns,
    // even if a fill turns the address into a hit meanwhile
    assign bus.miss_req  = miss_busy_q | miss_now;
    assign bus.miss_addr = req_addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            miss_busy_q <= 1'b0;
        end else begin
            miss_busy_q <= bus.miss_req & ~bus.rsp_vld;
        end
    end

    // Miss requests are accepted together with their RAM data
    assign req_rdy = hit_take | bus.rsp_vld;

    // ==================================================
    // Response register
    // ==================================================
    assign rsp_load = hit_take | bus.rsp_vld;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_vld <= 1'b0;
        end else if (rsp_load) begin
            rsp_vld <= 1'b1;
        end else if (rsp_rdy) begin
            rsp_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_load) rsp_dat <= bus.rsp_vld ? bus.rsp_dat : hit_dat;
    end

endmodule

// ==== src/wram_arbiter.sv ====
/*
 * Weight RAM arbiter
 * Round-robin grant of port misses, one read in flight,
 * routes RAM data back to the port and to the tag store
 */
`timescale 1ns/1ps
`include "weight_cache_config.svh"

module wram_arbiter (
    input  logic                    clk,
    input  logic                    rst_n,
    port_bus_if.arb                 bus [`WC_NUM_PORTS],
    output logic                    wram_req_vld,
    output weight_cache_pkg::addr_t wram_req_addr,
    input  logic                    wram_req_rdy,
    input  logic                    wram_rsp_vld,
    input  weight_cache_pkg::data_t wram_rsp_dat,
    output logic                    fill_vld,
    output weight_cache_pkg::addr_t fill_addr,
    output weight_cache_pkg::data_t fill_dat
);

    logic [`WC_NUM_PORTS-1:0]                    miss_req;
    weight_cache_pkg::addr_t [`WC_NUM_PORTS-1:0] miss_addr;
    logic                                        busy_q;
    logic                                        req_pend_q;
    weight_cache_pkg::port_idx_t                 grant_q;
    weight_cache_pkg::port_idx_t                 last_q;
    weight_cache_pkg::port_idx_t                 pick;
    logic                                        pick_vld;
    weight_cache_pkg::addr_t                     addr_q;
    logic                                        rsp_fire;

    // RAM data for the granted read
    assign rsp_fire = busy_q & ~req_pend_q & wram_rsp_vld;

    for (genvar p = 0; p < `WC_NUM_PORTS; p++) begin : g_bus
        assign miss_req[p]    = bus[p].miss_req;
        assign miss_addr[p]   = bus[p].miss_addr;
        assign bus[p].rsp_vld = rsp_fire & (grant_q == weight_cache_pkg::port_idx_t'(p));
        assign bus[p].rsp_dat = wram_rsp_dat;
    end

    // ==================================================
    // Round-robin pick, starting after the last grant
    // ==================================================
    always_comb begin
        weight_cache_pkg::port_idx_t cand;
        pick_vld = 1'b0;
        pick     = last_q;
        // Walk down so the nearest requester wins
        for (int k = `WC_NUM_PORTS; k >= 1; k--) begin
            cand = last_q + weight_cache_pkg::port_idx_t'(k);
            if (miss_req[cand]) begin
                pick_vld = 1'b1;
                pick     = cand;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q     <= 1'b0;
            req_pend_q <= 1'b0;
            grant_q    <= '0;
            last_q     <= '1;
        end else if (!busy_q) begin
            if (pick_vld) begin
                busy_q     <= 1'b1;
                req_pend_q <= 1'b1;
                grant_q    <= pick;
            end
        end else if (req_pend_q) begin
            if (wram_req_rdy) req_pend_q <= 1'b0;
        end else if (wram_rsp_vld) begin
            busy_q <= 1'b0;
            last_q <= grant_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy_q && pick_vld) addr_q <= miss_addr[pick];
    end

    assign wram_req_vld  = req_pend_q;
    assign wram_req_addr = addr_q;

    // Every RAM response is offered to the tag store
    assign fill_vld  = rsp_fire;
    assign fill_addr = addr_q;
    assign fill_dat  = wram_rsp_dat;

endmodule

// ==== src/weight_cache.sv ====
/*
 * Weight cache top level
 * Job controller, tag store, PE ports and weight RAM arbiter
 */
`timescale 1ns/1ps
`include "weight_cache_config.svh"

module weight_cache (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        cfg_vld,
    input  logic                                        cfg_cache_en,
    output logic                                        cfg_rdy,
    input  logic                                        idx_vld,
    output logic                                        idx_rdy,
    input  weight_cache_pkg::addr_t                     idx_addr,
    input  logic [`WC_NUM_PORTS-1:0]                    req_vld,
    output logic [`WC_NUM_PORTS-1:0]                    req_rdy,
    input  weight_cache_pkg::addr_t [`WC_NUM_PORTS-1:0] req_addr,
    output logic [`WC_NUM_PORTS-1:0]                    rsp_vld,
    input  logic [`WC_NUM_PORTS-1:0]                    rsp_rdy,
    output weight_cache_pkg::data_t [`WC_NUM_PORTS-1:0] rsp_dat,
    output logic                                        wram_req_vld,
    input  logic                                        wram_req_rdy,
    output weight_cache_pkg::addr_t                     wram_req_addr,
    input  logic                                        wram_rsp_vld,
    input  weight_cache_pkg::data_t                     wram_rsp_dat
);

    logic                                        work;
    logic                                        cache_en;
    weight_cache_pkg::addr_t [`WC_NUM_PORTS-1:0] lookup_addr;
    logic [`WC_NUM_PORTS-1:0]                    hit;
    weight_cache_pkg::data_t [`WC_NUM_PORTS-1:0] hit_dat;
    logic                                        fill_vld;
    weight_cache_pkg::addr_t                     fill_addr;
    weight_cache_pkg::data_t                     fill_dat;

    port_bus_if u_bus [`WC_NUM_PORTS] ();

    cache_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_vld      (cfg_vld),
        .cfg_cache_en (cfg_cache_en),
        .cfg_rdy      (cfg_rdy),
        .work         (work),
        .cache_en     (cache_en)
    );

    weight_tag_store u_tags (
        .clk         (clk),
        .rst_n       (rst_n),
        .work        (work),
        .cache_en    (cache_en),
        .idx_vld     (idx_vld),
        .idx_addr    (idx_addr),
        .idx_rdy     (idx_rdy),
        .fill_vld    (fill_vld),
        .fill_addr   (fill_addr),
        .fill_dat    (fill_dat),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .hit_dat     (hit_dat)
    );

    // One request/response port per PE row
    for (genvar p = 0; p < `WC_NUM_PORTS; p++) begin : g_port
        weight_port u_port (
            .clk         (clk),
            .rst_n       (rst_n),
            .work        (work),
            .req_vld     (req_vld[p]),
            .req_addr    (req_addr[p]),
            .req_rdy     (req_rdy[p]),
            .rsp_rdy     (rsp_rdy[p]),
            .rsp_vld     (rsp_vld[p]),
            .rsp_dat     (rsp_dat[p]),
            .lookup_addr (lookup_addr[p]),
            .hit         (hit[p]),
            .hit_dat     (hit_dat[p]),
            .bus         (u_bus[p])
        );
    end

    wram_arbiter u_arb (
        .clk           (clk),
        .rst_n         (rst_n),
        .bus           (u_bus),
        .wram_req_vld  (wram_req_vld),
        .wram_req_addr (wram_req_addr),
        .wram_req_rdy  (wram_req_rdy),
        .wram_rsp_vld  (wram_rsp_vld),
        .wram_rsp_dat  (wram_rsp_dat),
        .fill_vld      (fill_vld),
        .fill_addr     (fill_addr),
        .fill_dat      (fill_dat)
    );

endmodule

// ==== verification/weight_cache_sva.sv ====
/*
 * Weight cache protocol assertions
 * Response hold under back-pressure, one RAM read in flight,
 * index stream only open in cache mode
 */
`timescale 1ns/1ps
`include "weight_cache_config.svh"

module weight_cache_sva (
    input logic                                        clk,
    input logic                                        rst_n,
    input logic                                        cfg_vld,
    input logic                                        cfg_cache_en,
    input logic                                        cfg_rdy,
    input logic [`WC_NUM_PORTS-1:0]                    rsp_vld,
    input logic [`WC_NUM_PORTS-1:0]                    rsp_rdy,
    input weight_cache_pkg::data_t [`WC_NUM_PORTS-1:0] rsp_dat,
    input logic                                        wram_req_vld,
    input logic                                        wram_req_rdy,
    input logic                                        wram_rsp_vld,
    input logic                                        idx_rdy
);

    logic rd_out_q;
    logic cfg_seen_q;
    logic cache_job_q;

    // RAM read accepted but not yet answered
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_out_q <= 1'b0;
        end else if (wram_req_vld && wram_req_rdy) begin
            rd_out_q <= 1'b1;
        end else if (wram_rsp_vld) begin
            rd_out_q <= 1'b0;
        end
    end

    // Job mode seen from the configuration port, taken as config ends
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_seen_q  <= 1'b0;
            cache_job_q <= 1'b0;
        end else begin
            cfg_seen_q <= cfg_vld && cfg_rdy;
            if (cfg_seen_q) begin
                cache_job_q <= cfg_cache_en;
            end else if (cfg_rdy) begin
                cache_job_q <= 1'b0;
            end
        end
    end

    for (genvar p = 0; p < `WC_NUM_PORTS; p++) begin : g_hold
        a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
            rsp_vld[p] && !rsp_rdy[p] |=> $stable(rsp_dat[p]))
            else $error("rsp_dat[%0d] changed while stalled", p);
    end

    a_one_read: assert property (@(posedge clk) disable iff (!rst_n)
        rd_out_q |-> !wram_req_vld)
        else $error("wram_req_vld raised with a read outstanding");

    a_idx_mode: assert property (@(posedge clk) disable iff (!rst_n)
        idx_rdy |-> cache_job_q && !cfg_rdy && !cfg_seen_q)
        else $error("idx_rdy high outside cache mode");

endmodule

bind weight_cache weight_cache_sva u_sva (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_vld      (cfg_vld),
    .cfg_cache_en (cfg_cache_en),
    .cfg_rdy      (cfg_rdy),
    .rsp_vld      (rsp_vld),
    .rsp_rdy      (rsp_rdy),
    .rsp_dat      (rsp_dat),
    .wram_req_vld (wram_req_vld),
    .wram_req_rdy (wram_req_rdy),
    .wram_rsp_vld (wram_rsp_vld),
    .idx_rdy      (idx_rdy)
);

// ==== verification/weight_cache_checker.sv ====
/*
 * Weight cache checker
 * Tracks accepted requests per port, compares every response with
 * the weight RAM contents, counts RAM reads and reports per test
 */
`timescale 1ns/1ps
`include "weight_cache_config.svh"

module weight_cache_checker (
    input logic                                        clk,
    input logic                                        rst_n,
    input logic                                        cfg_rdy,
    input logic [`WC_NUM_PORTS-1:0]                    req_vld,
    input logic [`WC_NUM_PORTS-1:0]                    req_rdy,
    input weight_cache_pkg::addr_t [`WC_NUM_PORTS-1:0] req_addr,
    input logic [`WC_NUM_PORTS-1:0]                    rsp_vld,
    input logic [`WC_NUM_PORTS-1:0]                    rsp_rdy,
    input weight_cache_pkg::data_t [`WC_NUM_PORTS-1:0] rsp_dat,
    input logic                                        wram_req_vld,
    input logic                                        wram_req_rdy
);

    weight_cache_pkg::addr_t exp_q [`WC_NUM_PORTS][$];
    weight_cache_pkg::addr_t addr;

    int acc_cnt = 0;
    int ram_cnt = 0;
    int mon_err = 0;
    int chk_err = 0;
    int base_acc = 0;
    int base_ram = 0;
    int base_err = 0;
    int tests_run = 0;
    int tests_failed = 0;

    // RAM word: low byte XOR the upper address bits
    function automatic weight_cache_pkg::data_t ram_word(input weight_cache_pkg::addr_t a);
        return a[7:0] ^ {3'b000, a[12:8]};
    endfunction

    function automatic int outstanding();
        int n;
        n = 0;
        for (int p = 0; p < `WC_NUM_PORTS; p++) begin
            n += exp_q[p].size();
        end
        return n;
    endfunction

    function automatic int error_count();
        return mon_err + chk_err;
    endfunction

    // ==================================================
    // Handshake monitor, sampled mid-cycle
    // ==================================================
    always @(negedge clk) begin
        if (rst_n) begin
            for (int p = 0; p < `WC_NUM_PORTS; p++) begin
                // Response first, it always belongs to an older request
                if (rsp_vld[p] && rsp_rdy[p]) begin
                    if (exp_q[p].size() == 0) begin
                        $display("Port %0d returned a response with no request pending", p);
                        mon_err++;
                    end else begin
                        addr = exp_q[p].pop_front();
                        if (rsp_dat[p] !== ram_word(addr)) begin
                            $display("CHECK FAILED rsp_dat[%0d] addr 0x%h: got 0x%h expected 0x%h",
                                     p, addr, rsp_dat[p], ram_word(addr));
                            mon_err++;
                        end
                    end
                end
                if (req_vld[p] && req_rdy[p]) begin
                    exp_q[p].push_back(req_addr[p]);
                    acc_cnt++;
                end
            end
            if (wram_req_vld && wram_req_rdy) ram_cnt++;
            if (cfg_rdy && (rsp_vld != '0 || wram_req_vld)) begin
                $display("Response or RAM read seen while the cache is idle");
                mon_err++;
            end
        end
    end

    task automatic check_reset_state();
        if (cfg_rdy !== 1'b1) begin
            $display("CHECK FAILED cfg_rdy: got 0x%h expected 0x1", cfg_rdy);
            chk_err++;
        end
        if (rsp_vld !== '0) begin
            $display("CHECK FAILED rsp_vld: got 0x%h expected 0x0", rsp_vld);
            chk_err++;
        end
        if (wram_req_vld !== 1'b0) begin
            $display("CHECK FAILED wram_req_vld: got 0x%h expected 0x0", wram_req_vld);
            chk_err++;
        end
    endtask

    // Closes a test; optionally RAM reads must match accepts or be zero
    task automatic finish_test(input string name, input bit ram_eq_acc, input bit no_ram);
        int acc_d;
        int ram_d;
        acc_d = acc_cnt - base_acc;
        ram_d = ram_cnt - base_ram;
        if (outstanding() != 0) begin
            $display("%0d responses never arrived in test %s", outstanding(), name);
            chk_err++;
        end
        if (ram_eq_acc && ram_d != acc_d) begin
            $display("CHECK FAILED wram reads: got 0x%h expected 0x%h", ram_d, acc_d);
            chk_err++;
        end
        if (no_ram && ram_d != 0) begin
            $display("CHECK FAILED wram reads: got 0x%h expected 0x0", ram_d);
            chk_err++;
        end
        tests_run++;
        if (error_count() != base_err) tests_failed++;
        $display("Test %s: %s, %0d requests, %0d RAM reads", name,
                 (error_count() != base_err) ? "FAILED" : "ok", acc_d, ram_d);
        base_acc = acc_cnt;
        base_ram = ram_cnt;
        base_err = error_count();
    endtask

endmodule

// ==== verification/tb_weight_cache.sv ====
/*
 * Weight cache testbench
 * Clock, reset, weight RAM model, random request drivers and the
 * job sequence: bypass, preload, hits, back-pressure, new job
 */
`timescale 1ns/1ps
`include "weight_cache_config.svh"

module tb_weight_cache;

    localparam int NP      = `WC_NUM_PORTS;
    localparam int TIMEOUT = 6000;

    logic                                 clk = 1'b0;
    logic                                 rst_n = 1'b0;
    logic                                 cfg_vld = 1'b0;
    logic                                 cfg_cache_en = 1'b0;
    logic                                 cfg_rdy;
    logic                                 idx_vld = 1'b0;
    logic                                 idx_rdy;
    weight_cache_pkg::addr_t              idx_addr = '0;
    logic [NP-1:0]                        req_vld = '0;
    logic [NP-1:0]                        req_rdy;
    weight_cache_pkg::addr_t [NP-1:0]     req_addr = '0;
    logic [NP-1:0]                        rsp_vld;
    logic [NP-1:0]                        rsp_rdy = '0;
    weight_cache_pkg::data_t [NP-1:0]     rsp_dat;
    logic                                 wram_req_vld;
    logic                                 wram_req_rdy = 1'b0;
    weight_cache_pkg::addr_t              wram_req_addr;
    logic                                 wram_rsp_vld = 1'b0;
    weight_cache_pkg::data_t              wram_rsp_dat = '0;

    // Phase control from the main sequence
    int                      issue_target = 0;
    int                      phase_seq = 0;
    logic [NP-1:0]           port_mask = '0;
    int                      addr_mode = 0;
    logic                    rand_rdy = 1'b0;
    weight_cache_pkg::addr_t fixed_addr = '0;

    // Driver and RAM model state
    int                      seed = 32'h7bb0;
    int                      issued = 0;
    int                      seen_seq = 0;
    logic                    ram_busy = 1'b0;
    int                      ram_wait = 0;
    weight_cache_pkg::addr_t ram_addr = '0;
    weight_cache_pkg::addr_t pre_addr [8];
    logic                    timed_out = 1'b0;
    event                    stop_run;

    always #5 clk = ~clk;

    weight_cache u_dut (.*);

    weight_cache_checker u_chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_rdy      (cfg_rdy),
        .req_vld      (req_vld),
        .req_rdy      (req_rdy),
        .req_addr     (req_addr),
        .rsp_vld      (rsp_vld),
        .rsp_rdy      (rsp_rdy),
        .rsp_dat      (rsp_dat),
        .wram_req_vld (wram_req_vld),
        .wram_req_rdy (wram_req_rdy)
    );

    // 0 random, 1 preloaded, 2 mixed, 3 fixed
    function automatic weight_cache_pkg::addr_t pick_addr(input logic [31:0] r);
        case (addr_mode)
            1:       return pre_addr[r[10:8]];
            2:       return r[3] ? pre_addr[r[10:8]] : r[24:12];
            3:       return fixed_addr;
            default: return r[24:12];
        endcase
    endfunction

    // ==================================================
    // Request drivers and weight RAM model
    // ==================================================
    always @(posedge clk) begin
        int          n;
        logic [31:0] rnd;
        n = (seen_seq == phase_seq) ? issued : 0;
        for (int p = 0; p < NP; p++) begin
            rnd = $random(seed);
            if (!req_vld[p] || req_rdy[p]) begin
                if (port_mask[p] && n < issue_target && rnd[1:0] != 2'b00) begin
                    req_vld[p]  <= 1'b1;
                    req_addr[p] <= pick_addr(rnd);
                    n++;
                end else begin
                    req_vld[p] <= 1'b0;
                end
            end
            rsp_rdy[p] <= rand_rdy ? rnd[2] : 1'b1;
        end
        issued   <= n;
        seen_seq <= phase_seq;

        rnd = $random(seed);
        wram_rsp_vld <= 1'b0;
        if (ram_busy) begin
            if (ram_wait == 0) begin
                wram_rsp_vld <= 1'b1;
                wram_rsp_dat <= ram_addr[7:0] ^ {3'b000, ram_addr[12:8]};
                ram_busy     <= 1'b0;
            end else begin
                ram_wait <= ram_wait - 1;
            end
        end else if (wram_req_vld && wram_req_rdy) begin
            ram_busy     <= 1'b1;
            ram_addr     <= wram_req_addr;
            ram_wait     <= int'(rnd[1:0]);
            wram_req_rdy <= 1'b0;
        end else begin
            wram_req_rdy <= rnd[2];
        end
    end

    task automatic hang(input string what);
        $display("Timeout while waiting for %s", what);
        timed_out = 1'b1;
        -> stop_run;
        forever @(posedge clk);
    endtask

    task automatic wait_cfg_rdy();
        int t;
        t = 0;
        @(posedge clk);
        while (cfg_rdy !== 1'b1) begin
            if (t >= TIMEOUT) hang("cfg_rdy");
            t++;
            @(posedge clk);
        end
    endtask

    task automatic wait_drained(input string what);
        int t;
        t = 0;
        @(posedge clk);
        while (!(seen_seq == phase_seq && issued >= issue_target && req_vld == '0 &&
                 rsp_vld == '0 && !ram_busy && !wram_req_vld &&
                 u_chk.outstanding() == 0)) begin
            if (t >= TIMEOUT) hang(what);
            t++;
            @(posedge clk);
        end
    endtask

    task automatic run_phase(input int n, input logic [NP-1:0] mask, input int mode,
                             input logic rdy_rand, input weight_cache_pkg::addr_t fixed);
        @(posedge clk);
        issue_target <= n;
        port_mask    <= mask;
        addr_mode    <= mode;
        rand_rdy     <= rdy_rand;
        fixed_addr   <= fixed;
        phase_seq    <= phase_seq + 1;
        wait_drained("requests to drain");
    endtask

    task automatic start_job(input logic cache_mode);
        wait_cfg_rdy();
        cfg_vld      <= 1'b1;
        cfg_cache_en <= cache_mode;
        @(posedge clk);
        cfg_vld <= 1'b0;
        // Config, then work
        repeat (2) @(posedge clk);
    endtask

    task automatic end_job();
        @(posedge clk);
        cfg_vld <= 1'b1;
        @(posedge clk);
        cfg_vld <= 1'b0;
        wait_cfg_rdy();
    endtask

    task automatic preload_all();
        int t;
        t = 0;
        while (idx_rdy !== 1'b1) begin
            if (t >= TIMEOUT) hang("idx_rdy");
            t++;
            @(posedge clk);
        end
        for (int i = 0; i < 8; i++) begin
            idx_vld  <= 1'b1;
            idx_addr <= pre_addr[i];
            @(posedge clk);
        end
        idx_vld <= 1'b0;
    endtask

    // ==================================================
    // Job sequence
    // ==================================================
    initial begin
        for (int i = 0; i < 8; i++) begin
            pre_addr[i] = weight_cache_pkg::addr_t'(i * 613 + 97);
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            u_chk.check_reset_state();
        end
        u_chk.finish_test("reset", 1'b0, 1'b0);

        start_job(1'b0);
        run_phase(120, '1, 0, 1'b0, '0);
        u_chk.finish_test("bypass", 1'b1, 1'b0);
        end_job();

        start_job(1'b1);
        preload_all();
        for (int i = 0; i < 8; i++) begin
            run_phase(1, 4'b0001, 3, 1'b0, pre_addr[i]);
        end
        u_chk.finish_test("preload_miss", 1'b1, 1'b0);
        run_phase(150, '1, 1, 1'b0, '0);
        u_chk.finish_test("cache_hits", 1'b0, 1'b1);
        run_phase(150, '1, 2, 1'b1, '0);
        u_chk.finish_test("backpressure", 1'b0, 1'b0);
        end_job();

        // Store was cleared on the way to idle
        start_job(1'b1);
        run_phase(80, '1, 1, 1'b1, '0);
        u_chk.finish_test("new_job", 1'b1, 1'b0);
        end_job();
        -> stop_run;
    end

    initial begin
        @(stop_run);
        $display("Tests run %0d, failed %0d, errors %0d", u_chk.tests_run,
                 u_chk.tests_failed, u_chk.error_count());
        if (!timed_out && u_chk.tests_failed == 0 && u_chk.error_count() == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+src
src/weight_cache_pkg.sv
src/port_bus_if.sv
src/cache_ctrl.sv
src/weight_tag_store.sv
src/weight_port.sv
src/wram_arbiter.sv
src/weight_cache.sv
verification/weight_cache_sva.sv
verification/weight_cache_checker.sv
verification/tb_weight_cache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the weight cache testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module tb_weight_cache \
    -o sim_weight_cache

./obj_dir/sim_weight_cache | tee sim.log

if grep -q "^Done: no errors$" sim.log; then
    echo "Simulation PASSED"
    exit 0
else
    echo "Simulation FAILED"
    exit 1
fi
